// ==== dram_ctrl_pkg.sv ====
`default_nettype none

package dram_ctrl_pkg;

  // AXI side widths
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 8;
  localparam int AXI_RESP_W = 2;

  // Device side widths and address split
  localparam int ROW_W   = 11;
  localparam int COL_W   = 10;
  localparam int ROW_LSB = 12;
  localparam int COL_LSB = 2;
  localparam int DADDR_W = 11;
  localparam int WEN_W   = AXI_STRB_W;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;
  typedef logic [ROW_W-1:0]      dram_row_t;
  typedef logic [COL_W-1:0]      dram_col_t;
  typedef logic [DADDR_W-1:0]    dram_addr_t;
  typedef logic [WEN_W-1:0]      dram_wen_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Active pin levels
  localparam logic RAS_ENB = 1'b0;
  localparam logic CAS_ENB = 1'b0;
  localparam logic WEB_ENB = 1'b0;
  localparam logic CS_ENB  = 1'b0;

  typedef enum logic {
    DRAM_READ,
    DRAM_WRITE
  } dram_op_t;

  typedef enum logic [2:0] {
    IDLE,
    PRE,
    ACT,
    RCD,
    COL_RD,
    COL_WR,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

// ==== dram_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dram_req_if;

  logic                     req_valid;
  dram_ctrl_pkg::dram_op_t  op;
  dram_ctrl_pkg::dram_row_t row;
  dram_ctrl_pkg::dram_col_t col;
  dram_ctrl_pkg::axi_data_t wdata;
  dram_ctrl_pkg::axi_strb_t wstrb;
  dram_ctrl_pkg::axi_id_t   id;
  // High while the sequencer owns a transaction
  logic                     busy;

  modport decode (output req_valid, op, row, col, wdata, wstrb, id, input busy);

  modport exec (input req_valid, op, row, col, wdata, wstrb, id, output busy);

  modport resp (input id, op);

endinterface

`default_nettype wire

// ==== dram_rsp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dram_rsp_if;

  // Read word from Q, valid for one cycle
  logic                     rd_valid;
  dram_ctrl_pkg::axi_data_t rd_data;
  // Write column command issued
  logic                     wr_done;
  // R or B handshake seen
  logic                     resp_done;

  modport exec (output rd_valid, rd_data, wr_done, input resp_done);

  modport resp (input rd_valid, rd_data, wr_done, output resp_done);

endinterface

`default_nettype wire

// ==== axi_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_req_decode (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     awvalid,
  input  dram_ctrl_pkg::axi_addr_t awaddr,
  input  dram_ctrl_pkg::axi_id_t   awid,
  output logic                     awready,
  input  logic                     wvalid,
  input  dram_ctrl_pkg::axi_data_t wdata,
  input  dram_ctrl_pkg::axi_strb_t wstrb,
  output logic                     wready,
  input  logic                     arvalid,
  input  dram_ctrl_pkg::axi_addr_t araddr,
  input  dram_ctrl_pkg::axi_id_t   arid,
  output logic                     arready,
  dram_req_if.decode               req
);

  logic accept_en;
  logic can_take;
  logic aw_hs;
  logic ar_hs;

  // Open for requests only from the cycle after reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      accept_en <= 1'b0;
    end else begin
      accept_en <= 1'b1;
    end
  end

  // req_valid doubles as the pending flag
  assign can_take = accept_en & ~req.busy & ~req.req_valid;

  // AW and W only together; writes win over reads
  assign awready = can_take & awvalid & wvalid;
  assign wready  = can_take & awvalid & wvalid;
  assign arready = can_take & ~awvalid;

  assign aw_hs = awvalid & awready;
  assign ar_hs = arvalid & arready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req.req_valid <= 1'b0;
    end else begin
      req.req_valid <= aw_hs | ar_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      req.op    <= dram_ctrl_pkg::DRAM_WRITE;
      req.row   <= awaddr[dram_ctrl_pkg::ROW_LSB +: dram_ctrl_pkg::ROW_W];
      req.col   <= awaddr[dram_ctrl_pkg::COL_LSB +: dram_ctrl_pkg::COL_W];
      req.id    <= awid;
      req.wdata <= wdata;
      req.wstrb <= wstrb;
    end else if (ar_hs) begin
      req.op  <= dram_ctrl_pkg::DRAM_READ;
      req.row <= araddr[dram_ctrl_pkg::ROW_LSB +: dram_ctrl_pkg::ROW_W];
      req.col <= araddr[dram_ctrl_pkg::COL_LSB +: dram_ctrl_pkg::COL_W];
      req.id  <= arid;
    end
  end

  // A new request must never overlap a running transaction
  a_no_req_while_busy: assert property (
    @(posedge clk) disable iff (!rstn) req.req_valid |-> !req.busy
  );

endmodule

`default_nettype wire

// ==== dram_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_seq #(
  parameter int T_RCD = 3
) (
  input  logic                      clk,
  input  logic                      rstn,
  dram_req_if.exec                  req,
  dram_rsp_if.exec                  rsp,
  output logic                      dram_csn,
  output logic                      dram_rasn,
  output logic                      dram_casn,
  output dram_ctrl_pkg::dram_wen_t  dram_wen,
  output dram_ctrl_pkg::dram_addr_t dram_a,
  output dram_ctrl_pkg::axi_data_t  dram_d,
  input  dram_ctrl_pkg::axi_data_t  dram_q,
  input  logic                      dram_valid
);

  localparam int CNT_W = $clog2(T_RCD);

  dram_ctrl_pkg::seq_state_t state;
  dram_ctrl_pkg::seq_state_t next_state;
  dram_ctrl_pkg::seq_state_t col_state;
  dram_ctrl_pkg::dram_row_t  open_row;
  logic                      open_vld;
  logic                      row_hit;
  logic [CNT_W-1:0]          rcd_cnt;

  if (T_RCD < 2) begin : g_bad_trcd
    $error("T_RCD must be at least 2");
  end

  assign row_hit   = open_vld && (open_row == req.row);
  assign col_state = (req.op == dram_ctrl_pkg::DRAM_WRITE) ? dram_ctrl_pkg::COL_WR
                                                           : dram_ctrl_pkg::COL_RD;

  always_comb begin
    next_state = state;
    case (state)
      dram_ctrl_pkg::IDLE: begin
        if (req.req_valid) begin
          if (row_hit) begin
            next_state = col_state;
          end else if (open_vld) begin
            next_state = dram_ctrl_pkg::PRE;
          end else begin
            next_state = dram_ctrl_pkg::ACT;
          end
        end
      end
      dram_ctrl_pkg::PRE:    next_state = dram_ctrl_pkg::ACT;
      dram_ctrl_pkg::ACT:    next_state = dram_ctrl_pkg::RCD;
      dram_ctrl_pkg::RCD:    next_state = (rcd_cnt == '0) ? col_state : dram_ctrl_pkg::RCD;
      dram_ctrl_pkg::COL_RD: next_state = dram_valid ? dram_ctrl_pkg::DONE : dram_ctrl_pkg::COL_RD;
      dram_ctrl_pkg::COL_WR: next_state = dram_ctrl_pkg::DONE;
      dram_ctrl_pkg::DONE:   next_state = rsp.resp_done ? dram_ctrl_pkg::IDLE : dram_ctrl_pkg::DONE;
      default:               next_state = dram_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= dram_ctrl_pkg::IDLE;
      open_vld <= 1'b0;
      open_row <= '0;
      rcd_cnt  <= '0;
    end else begin
      state <= next_state;
      if (state == dram_ctrl_pkg::ACT) begin
        open_vld <= 1'b1;
        open_row <= req.row;
        // ACT and the column cycle bracket T_RCD-1 wait cycles
        rcd_cnt  <= CNT_W'(T_RCD - 2);
      end else if (state == dram_ctrl_pkg::RCD) begin
        rcd_cnt <= rcd_cnt - 1'b1;
      end
    end
  end

  // Pins follow the state they belong to
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dram_rasn <= ~dram_ctrl_pkg::RAS_ENB;
      dram_casn <= ~dram_ctrl_pkg::CAS_ENB;
      dram_wen  <= {dram_ctrl_pkg::WEN_W{~dram_ctrl_pkg::WEB_ENB}};
    end else begin
      dram_rasn <= ~dram_ctrl_pkg::RAS_ENB;
      dram_casn <= ~dram_ctrl_pkg::CAS_ENB;
      dram_wen  <= {dram_ctrl_pkg::WEN_W{~dram_ctrl_pkg::WEB_ENB}};
      case (next_state)
        dram_ctrl_pkg::PRE: begin
          dram_rasn <= dram_ctrl_pkg::RAS_ENB;
          dram_wen  <= {dram_ctrl_pkg::WEN_W{dram_ctrl_pkg::WEB_ENB}};
        end
        dram_ctrl_pkg::ACT: dram_rasn <= dram_ctrl_pkg::RAS_ENB;
        dram_ctrl_pkg::COL_WR: begin
          dram_casn <= dram_ctrl_pkg::CAS_ENB;
          dram_wen  <= ~req.wstrb;
        end
        // Read command only on entry, then wait for Q
        dram_ctrl_pkg::COL_RD: begin
          if (state != dram_ctrl_pkg::COL_RD) begin
            dram_casn <= dram_ctrl_pkg::CAS_ENB;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (next_state)
      dram_ctrl_pkg::PRE: dram_a <= open_row;
      dram_ctrl_pkg::ACT: dram_a <= req.row;
      default:            dram_a <= {1'b0, req.col};
    endcase
    if (next_state == dram_ctrl_pkg::COL_WR) begin
      dram_d <= req.wdata;
    end
  end

  assign dram_csn     = dram_ctrl_pkg::CS_ENB;
  assign req.busy     = (state != dram_ctrl_pkg::IDLE);
  assign rsp.rd_valid = (state == dram_ctrl_pkg::COL_RD) && dram_valid;
  assign rsp.rd_data  = dram_q;
  assign rsp.wr_done  = (state == dram_ctrl_pkg::COL_WR);

  a_ras_cas_excl: assert property (
    @(posedge clk) disable iff (!rstn)
      !(dram_rasn == dram_ctrl_pkg::RAS_ENB && dram_casn == dram_ctrl_pkg::CAS_ENB)
  );

  // Device must only answer an outstanding read
  a_valid_in_col_rd: assert property (
    @(posedge clk) disable iff (!rstn) dram_valid |-> state == dram_ctrl_pkg::COL_RD
  );

endmodule

`default_nettype wire

// ==== axi_resp_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_resp_gen (
  input  logic                     clk,
  input  logic                     rstn,
  dram_req_if.resp                 req,
  dram_rsp_if.resp                 rsp,
  output logic                     rvalid,
  output dram_ctrl_pkg::axi_data_t rdata,
  output dram_ctrl_pkg::axi_id_t   rid,
  output dram_ctrl_pkg::axi_resp_t rresp,
  output logic                     rlast,
  input  logic                     rready,
  output logic                     bvalid,
  output dram_ctrl_pkg::axi_id_t   bid,
  output dram_ctrl_pkg::axi_resp_t bresp,
  input  logic                     bready
);

  dram_ctrl_pkg::axi_id_t id_q;
  logic                   r_set;
  logic                   b_set;

  assign r_set = rsp.rd_valid && (req.op == dram_ctrl_pkg::DRAM_READ);
  assign b_set = rsp.wr_done && (req.op == dram_ctrl_pkg::DRAM_WRITE);

  // Valids stay up until the master takes them
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (r_set) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (b_set) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (r_set) begin
      rdata <= rsp.rd_data;
    end
    if (r_set || b_set) begin
      id_q <= req.id;
    end
  end

  assign rid   = id_q;
  assign bid   = id_q;
  assign rresp = dram_ctrl_pkg::RESP_OKAY;
  assign bresp = dram_ctrl_pkg::RESP_OKAY;
  // Single beat only
  assign rlast = 1'b1;

  assign rsp.resp_done = (rvalid & rready) | (bvalid & bready);

  a_one_resp: assert property (
    @(posedge clk) disable iff (!rstn) !(rvalid && bvalid)
  );

endmodule

`default_nettype wire

// ==== dram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_ctrl_top #(
  parameter int T_RCD = 3
) (
  input  logic                      clk,
  input  logic                      rstn,
  // AXI slave
  input  logic                      awvalid,
  input  dram_ctrl_pkg::axi_addr_t  awaddr,
  input  dram_ctrl_pkg::axi_id_t    awid,
  output logic                      awready,
  input  logic                      wvalid,
  input  dram_ctrl_pkg::axi_data_t  wdata,
  input  dram_ctrl_pkg::axi_strb_t  wstrb,
  output logic                      wready,
  input  logic                      arvalid,
  input  dram_ctrl_pkg::axi_addr_t  araddr,
  input  dram_ctrl_pkg::axi_id_t    arid,
  output logic                      arready,
  output logic                      rvalid,
  output dram_ctrl_pkg::axi_data_t  rdata,
  output dram_ctrl_pkg::axi_id_t    rid,
  output dram_ctrl_pkg::axi_resp_t  rresp,
  output logic                      rlast,
  input  logic                      rready,
  output logic                      bvalid,
  output dram_ctrl_pkg::axi_id_t    bid,
  output dram_ctrl_pkg::axi_resp_t  bresp,
  input  logic                      bready,
  // Device pins
  output logic                      dram_csn,
  output logic                      dram_rasn,
  output logic                      dram_casn,
  output dram_ctrl_pkg::dram_wen_t  dram_wen,
  output dram_ctrl_pkg::dram_addr_t dram_a,
  output dram_ctrl_pkg::axi_data_t  dram_d,
  input  dram_ctrl_pkg::axi_data_t  dram_q,
  input  logic                      dram_valid
);

  dram_req_if req_bus ();
  dram_rsp_if rsp_bus ();

  axi_req_decode u_decode (
    .clk, .rstn,
    .awvalid, .awaddr, .awid, .awready,
    .wvalid, .wdata, .wstrb, .wready,
    .arvalid, .araddr, .arid, .arready,
    .req (req_bus.decode)
  );

  dram_cmd_seq #(.T_RCD(T_RCD)) u_seq (
    .clk, .rstn,
    .req (req_bus.exec),
    .rsp (rsp_bus.exec),
    .dram_csn, .dram_rasn, .dram_casn, .dram_wen, .dram_a, .dram_d,
    .dram_q, .dram_valid
  );

  axi_resp_gen u_resp (
    .clk, .rstn,
    .req (req_bus.resp),
    .rsp (rsp_bus.resp),
    .rvalid, .rdata, .rid, .rresp, .rlast, .rready,
    .bvalid, .bid, .bresp, .bready
  );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== tb_dram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dram_model #(
  parameter int CAS_LAT  = 2,
  parameter bit LOG_CMDS = 1'b0
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      dram_csn,
  input  logic                      dram_rasn,
  input  logic                      dram_casn,
  input  dram_ctrl_pkg::dram_wen_t  dram_wen,
  input  dram_ctrl_pkg::dram_addr_t dram_a,
  input  dram_ctrl_pkg::axi_data_t  dram_d,
  output dram_ctrl_pkg::axi_data_t  dram_q,
  output logic                      dram_valid
);

  localparam int KEY_W = dram_ctrl_pkg::ROW_W + dram_ctrl_pkg::COL_W;
  localparam dram_ctrl_pkg::dram_wen_t WEN_OFF = {dram_ctrl_pkg::WEN_W{~dram_ctrl_pkg::WEB_ENB}};
  localparam dram_ctrl_pkg::dram_wen_t WEN_ON  = {dram_ctrl_pkg::WEN_W{dram_ctrl_pkg::WEB_ENB}};

  // Storage keyed by {row, column}
  dram_ctrl_pkg::axi_data_t mem [logic [KEY_W-1:0]];
  dram_ctrl_pkg::dram_row_t act_row;
  dram_ctrl_pkg::axi_data_t word;
  logic [CAS_LAT-1:0]       rd_pipe;
  logic [KEY_W-1:0]         key;
  logic                     sel;
  logic                     is_pre;
  logic                     is_act;
  logic                     is_wr;
  logic                     is_rd;

  assign sel        = (dram_csn == dram_ctrl_pkg::CS_ENB);
  assign is_pre     = sel && dram_rasn == dram_ctrl_pkg::RAS_ENB && dram_wen == WEN_ON;
  assign is_act     = sel && dram_rasn == dram_ctrl_pkg::RAS_ENB && dram_wen == WEN_OFF;
  assign is_wr      = sel && dram_casn == dram_ctrl_pkg::CAS_ENB && dram_wen != WEN_OFF;
  assign is_rd      = sel && dram_casn == dram_ctrl_pkg::CAS_ENB && dram_wen == WEN_OFF;
  assign key        = {act_row, dram_a[dram_ctrl_pkg::COL_W-1:0]};
  assign dram_valid = rd_pipe[CAS_LAT-1];

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_pipe <= '0;
      act_row <= '0;
      dram_q  <= '0;
    end else begin
      rd_pipe <= {rd_pipe[CAS_LAT-2:0], is_rd};
      if (is_act) begin
        act_row <= dram_a;
      end
      // Only bytes with WEn low change
      if (is_wr) begin
        word = mem.exists(key) ? mem[key] : '0;
        for (int b = 0; b < dram_ctrl_pkg::WEN_W; b++) begin
          if (dram_wen[b] == dram_ctrl_pkg::WEB_ENB) begin
            word[8*b +: 8] = dram_d[8*b +: 8];
          end
        end
        mem[key] = word;
      end
      if (is_rd) begin
        dram_q <= mem.exists(key) ? mem[key] : '0;
      end
      if (LOG_CMDS && (is_pre || is_act || is_wr || is_rd)) begin
        $display("dram cmd pre=%0b act=%0b wr=%0b rd=%0b a=%h",
                 is_pre, is_act, is_wr, is_rd, dram_a);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_dram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dram_ctrl;

  localparam int T_RCD   = 3;
  localparam int CAS_LAT = 2;
  localparam int TIMEOUT = 200;
  localparam dram_ctrl_pkg::dram_wen_t WEN_OFF = {dram_ctrl_pkg::WEN_W{~dram_ctrl_pkg::WEB_ENB}};
  localparam dram_ctrl_pkg::dram_wen_t WEN_ON  = {dram_ctrl_pkg::WEN_W{dram_ctrl_pkg::WEB_ENB}};

  logic clk;
  logic rstn;
  logic awvalid, awready, wvalid, wready, arvalid, arready;
  logic rvalid, rlast, rready, bvalid, bready;
  logic dram_csn, dram_rasn, dram_casn, dram_valid;
  dram_ctrl_pkg::axi_addr_t  awaddr, araddr;
  dram_ctrl_pkg::axi_id_t    awid, arid, rid, bid;
  dram_ctrl_pkg::axi_data_t  wdata, rdata, dram_d, dram_q;
  dram_ctrl_pkg::axi_strb_t  wstrb;
  dram_ctrl_pkg::axi_resp_t  rresp, bresp;
  dram_ctrl_pkg::dram_wen_t  dram_wen;
  dram_ctrl_pkg::dram_addr_t dram_a;

  // Command counts and cycles seen on the device pins
  int cyc = 0;
  int pre_cnt = 0;
  int act_cnt = 0;
  int col_cnt = 0;
  int pre_last = 0;
  int act_cyc[$];
  int col_cyc[$];

  tb_clkgen #(.PERIOD_NS(40)) u_clkgen (.clk(clk));

  dram_ctrl_top #(.T_RCD(T_RCD)) dut (.*);

  tb_dram_model #(.CAS_LAT(CAS_LAT), .LOG_CMDS(1'b1)) u_model (.*);

  always @(posedge clk) begin
    if (rstn) begin
      cyc = cyc + 1;
      if (dram_rasn == dram_ctrl_pkg::RAS_ENB && dram_wen == WEN_ON) begin
        pre_cnt  = pre_cnt + 1;
        pre_last = cyc;
      end
      if (dram_rasn == dram_ctrl_pkg::RAS_ENB && dram_wen == WEN_OFF) begin
        act_cnt = act_cnt + 1;
        act_cyc.push_back(cyc);
      end
      if (dram_casn == dram_ctrl_pkg::CAS_ENB) begin
        col_cnt = col_cnt + 1;
        col_cyc.push_back(cyc);
      end
    end
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_data(input string test, input dram_ctrl_pkg::axi_data_t expected,
                              input dram_ctrl_pkg::axi_data_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", test, expected, actual));
    end
  endtask

  task automatic compare_id(input string test, input dram_ctrl_pkg::axi_id_t expected,
                            input dram_ctrl_pkg::axi_id_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[FAIL] %s: expected id %h, actual id %h", test, expected, actual));
    end
  endtask

  task automatic compare_resp(input string test, input dram_ctrl_pkg::axi_resp_t expected,
                              input dram_ctrl_pkg::axi_resp_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("[FAIL] %s: expected resp %h, actual resp %h",
                              test, expected, actual));
    end
  endtask

  task automatic compare_count(input string test, input int expected, input int actual);
    if (actual != expected) begin
      stop_on_error($sformatf("[FAIL] %s: expected %0d, actual %0d", test, expected, actual));
    end
  endtask

  // One clock step of a bounded wait
  task automatic step_with_limit(input string what, inout int n);
    @(posedge clk);
    n++;
    if (n > TIMEOUT) begin
      stop_on_error($sformatf("Timeout while waiting for %s", what));
    end
  endtask

  function automatic dram_ctrl_pkg::axi_addr_t make_addr(input dram_ctrl_pkg::dram_row_t row,
                                                         input dram_ctrl_pkg::dram_col_t col);
    return {9'b0, row, col, 2'b00};
  endfunction

  task automatic do_write(input string test, input dram_ctrl_pkg::axi_addr_t addr,
                          input dram_ctrl_pkg::axi_data_t data,
                          input dram_ctrl_pkg::axi_strb_t strb, input dram_ctrl_pkg::axi_id_t id);
    int n;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    n = 0;
    do begin
      step_with_limit({test, " write accept"}, n);
    end while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      step_with_limit({test, " write response"}, n);
    end while (!(bvalid && bready));
    compare_id(test, id, bid);
    compare_resp(test, dram_ctrl_pkg::RESP_OKAY, bresp);
  endtask

  task automatic do_read(input string test, input dram_ctrl_pkg::axi_addr_t addr,
                         input dram_ctrl_pkg::axi_id_t id, output dram_ctrl_pkg::axi_data_t data);
    int n;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= id;
    n = 0;
    do begin
      step_with_limit({test, " read accept"}, n);
    end while (!arready);
    arvalid <= 1'b0;
    n = 0;
    do begin
      step_with_limit({test, " read response"}, n);
    end while (!(rvalid && rready));
    data = rdata;
    compare_id(test, id, rid);
    compare_resp(test, dram_ctrl_pkg::RESP_OKAY, rresp);
    if (rlast !== 1'b1) begin
      stop_on_error($sformatf("[FAIL] %s: expected rlast 1, actual rlast %b", test, rlast));
    end
  endtask

  task automatic check_reset_state();
    if (dram_csn != dram_ctrl_pkg::CS_ENB || dram_rasn == dram_ctrl_pkg::RAS_ENB ||
        dram_casn == dram_ctrl_pkg::CAS_ENB || dram_wen != WEN_OFF) begin
      stop_on_error("Device pins are not idle during reset");
    end
    if (rvalid || bvalid || arready) begin
      stop_on_error("An AXI valid or ready output is high during reset");
    end
  endtask

  task automatic row_policy_counts();
    dram_ctrl_pkg::axi_data_t word;
    dram_ctrl_pkg::axi_data_t got;
    word = $urandom();
    do_write("row_policy", make_addr(11'h021, 10'h004), word, 4'hf, 8'h11);
    compare_count("row_policy first ACT", 1, act_cnt);
    compare_count("row_policy first PRE", 0, pre_cnt);
    do_read("row_policy", make_addr(11'h021, 10'h004), 8'h12, got);
    compare_data("row_policy", word, got);
    compare_count("row_policy hit ACT", 1, act_cnt);
    compare_count("row_policy hit PRE", 0, pre_cnt);
    do_write("row_policy", make_addr(11'h3c5, 10'h004), word, 4'hf, 8'h13);
    compare_count("row_policy miss PRE", 1, pre_cnt);
    compare_count("row_policy miss ACT", 2, act_cnt);
    compare_count("row_policy PRE then ACT", pre_last + 1, act_cyc[$]);
    compare_count("row_policy column commands", 3, col_cnt);
  endtask

  task automatic write_then_read();
    dram_ctrl_pkg::axi_addr_t addr;
    dram_ctrl_pkg::axi_data_t word;
    dram_ctrl_pkg::axi_data_t got;
    addr = make_addr(dram_ctrl_pkg::dram_row_t'($urandom()),
                     dram_ctrl_pkg::dram_col_t'($urandom()));
    word = $urandom();
    do_write("write_read", addr, word, 4'hf, dram_ctrl_pkg::axi_id_t'($urandom()));
    do_read("write_read", addr, dram_ctrl_pkg::axi_id_t'($urandom()), got);
    compare_data("write_read", word, got);
  endtask

  task automatic strobe_merge();
    dram_ctrl_pkg::axi_addr_t addr;
    dram_ctrl_pkg::axi_data_t first;
    dram_ctrl_pkg::axi_data_t second;
    dram_ctrl_pkg::axi_data_t got;
    addr   = make_addr(11'h0a7, 10'h2f1);
    first  = $urandom();
    second = $urandom();
    do_write("byte_strobes", addr, first, 4'hf, 8'h21);
    do_write("byte_strobes", addr, second, 4'b0101, 8'h22);
    do_read("byte_strobes", addr, 8'h23, got);
    // Bytes 0 and 2 from the second word
    compare_data("byte_strobes", {first[31:24], second[23:16], first[15:8], second[7:0]}, got);
  endtask

  task automatic act_to_cas_delay();
    int j;
    do_write("rcd_timing", make_addr(11'h155, 10'h013), $urandom(), 4'hf, 8'h31);
    if (act_cyc.size() == 0) begin
      stop_on_error("rcd_timing: no ACT command was seen");
    end
    foreach (act_cyc[i]) begin
      j = 0;
      while (j < col_cyc.size() && col_cyc[j] <= act_cyc[i]) begin
        j++;
      end
      if (j == col_cyc.size()) begin
        stop_on_error("rcd_timing: an ACT command has no column command after it");
      end
      compare_count("rcd_timing", T_RCD, col_cyc[j] - act_cyc[i]);
    end
  endtask

  task automatic read_backpressure();
    dram_ctrl_pkg::axi_addr_t addr;
    dram_ctrl_pkg::axi_data_t word;
    dram_ctrl_pkg::axi_data_t held;
    int n;
    addr = make_addr(11'h2e0, 10'h07c);
    word = $urandom();
    do_write("backpressure", addr, word, 4'hf, 8'h41);
    @(posedge clk);
    rready  <= 1'b0;
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= 8'h42;
    n = 0;
    do begin
      step_with_limit("backpressure read accept", n);
    end while (!arready);
    arvalid <= 1'b0;
    n = 0;
    do begin
      step_with_limit("backpressure rvalid", n);
    end while (!rvalid);
    held = rdata;
    repeat (10) begin
      @(posedge clk);
      if (!rvalid) begin
        stop_on_error("backpressure: rvalid dropped while rready was low");
      end
      if (arready) begin
        stop_on_error("backpressure: arready rose while a response was pending");
      end
      compare_data("backpressure hold", held, rdata);
    end
    rready <= 1'b1;
    n = 0;
    do begin
      step_with_limit("backpressure read handshake", n);
    end while (!(rvalid && rready));
    compare_data("backpressure", word, rdata);
    compare_id("backpressure", 8'h42, rid);
  endtask

  task automatic write_before_read();
    dram_ctrl_pkg::axi_addr_t addr;
    dram_ctrl_pkg::axi_data_t word;
    dram_ctrl_pkg::axi_data_t got;
    int n;
    int b_at;
    int r_at;
    addr = make_addr(11'h611, 10'h1a0);
    word = $urandom();
    do_write("write_priority", addr, ~word, 4'hf, 8'h51);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= 8'h52;
    wvalid  <= 1'b1;
    wdata   <= word;
    wstrb   <= 4'hf;
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= 8'h53;
    n = 0;
    b_at = 0;
    r_at = 0;
    while (b_at == 0 || r_at == 0) begin
      step_with_limit("write_priority responses", n);
      if (awvalid && awready && wready) begin
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
      end
      if (arvalid && arready) begin
        arvalid <= 1'b0;
      end
      if (bvalid && bready && b_at == 0) begin
        b_at = n;
        compare_id("write_priority", 8'h52, bid);
      end
      if (rvalid && rready && r_at == 0) begin
        r_at = n;
        got  = rdata;
        compare_id("write_priority", 8'h53, rid);
      end
    end
    if (b_at >= r_at) begin
      stop_on_error("write_priority: the read response came before the write response");
    end
    compare_data("write_priority", word, got);
  endtask

  initial begin
    void'($urandom(68));
    rstn    = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    awid    = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    arvalid = 1'b0;
    araddr  = '0;
    arid    = '0;
    rready  = 1'b1;
    bready  = 1'b1;
    repeat (2) @(posedge clk);
    check_reset_state();
    rstn <= 1'b1;
    row_policy_counts();
    write_then_read();
    strobe_merge();
    act_to_cas_delay();
    read_backpressure();
    write_before_read();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
dram_ctrl_pkg.sv
dram_req_if.sv
dram_rsp_if.sv
axi_req_decode.sv
dram_cmd_seq.sv
axi_resp_gen.sv
dram_ctrl_top.sv
tb_clkgen.sv
tb_dram_model.sv
tb_dram_ctrl.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_dram_ctrl
FILELIST    = src.f
OBJ_DIR     = obj_dir
PASS_MSG    = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
